// ==== Makefile ====
VERILATOR ?= verilator
TOP := neo_cart_loader_tb
FILELIST := neo_cart_loader.f
OBJ_DIR := obj_dir
VFLAGS := --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/neo_cart_loader_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "neo_loader_config.svh"

module neo_cart_loader_tb
	import neo_loader_pkg::*;
();

	localparam int P1_AW = `NEO_PORT1_ADDR_W - 1;
	localparam int P2_AW = `NEO_PORT2_ADDR_W - 1;
	localparam int NUM_ENTRIES = 23;
	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = (NUM_ENTRIES + 25) * 12 + RESET_CYCLES + 100;

	// Port 0 means no request expected
	typedef struct packed {
		logic [7:0] index;
		logic [`NEO_IOCTL_ADDR_W-1:0] addr;
		logic [7:0] data;
		logic [1:0] port;
		logic [24:0] waddr;
		logic [1:0] ds;
	} beat_entry_t;

	logic CLK_48M;
	logic rst_n;
	ioctl_beat_t ioctl;
	logic download;
	logic p1_req;
	logic p1_ack;
	logic p2_req;
	logic p2_ack;
	logic [P1_AW-1:0] p1_addr;
	logic [P2_AW-1:0] p2_addr;
	sdram_wdata_t p1_wdata;
	sdram_wdata_t p2_wdata;
	logic [3:0] p1_delay;
	logic [3:0] p2_delay;
	logic [P1_AW-1:0] p1_last_addr;
	logic [P2_AW-1:0] p2_last_addr;
	sdram_wdata_t p1_last_wdata;
	sdram_wdata_t p2_last_wdata;
	int p1_writes;
	int p2_writes;

	beat_entry_t stim [NUM_ENTRIES];
	logic [31:0] lfsr;
	int cycles = 0;
	int checks;
	int errors;

	neo_cart_loader neo_cart_loader_inst (
		.CLK_48M(CLK_48M),
		.rst_n(rst_n),
		.ioctl(ioctl),
		.download(download),
		.p1_req(p1_req),
		.p1_addr(p1_addr),
		.p1_wdata(p1_wdata),
		.p1_ack(p1_ack),
		.p2_req(p2_req),
		.p2_addr(p2_addr),
		.p2_wdata(p2_wdata),
		.p2_ack(p2_ack)
	);

	sdram_port_model #(.ADDR_W(P1_AW)) p1_model (
		.CLK_48M(CLK_48M),
		.rst_n(rst_n),
		.delay(p1_delay),
		.req(p1_req),
		.addr(p1_addr),
		.wdata(p1_wdata),
		.ack(p1_ack),
		.last_addr(p1_last_addr),
		.last_wdata(p1_last_wdata),
		.writes(p1_writes)
	);

	sdram_port_model #(.ADDR_W(P2_AW)) p2_model (
		.CLK_48M(CLK_48M),
		.rst_n(rst_n),
		.delay(p2_delay),
		.req(p2_req),
		.addr(p2_addr),
		.wdata(p2_wdata),
		.ack(p2_ack),
		.last_addr(p2_last_addr),
		.last_wdata(p2_last_wdata),
		.writes(p2_writes)
	);

	initial CLK_48M = 1'b0;
	always #50 CLK_48M = ~CLK_48M;

	always @(posedge CLK_48M) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Run stopped by the timeout after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic pick_delay(output logic [3:0] d);
		logic [2:0] bits;
		for (int i = 0; i < 3; i++) begin
			lfsr = lfsr_next(lfsr);
			bits[i] = lfsr[0];
		end
		d = {1'b0, bits} + 4'd1;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			$display("%s", what);
			errors++;
		end
	endtask

	// Word addresses are byte address >> 1, strobe from byte address bit 0
	task automatic load_stimulus();
		// System ROM: SROM, LO ROM, SFIX, SM1
		stim[0] = '{8'd0, 25'h000_0000, 8'h11, 2'd1, 25'h07C_0000, 2'b01};
		stim[1] = '{8'd0, 25'h001_2345, 8'h22, 2'd1, 25'h07C_91A2, 2'b10};
		stim[2] = '{8'd1, 25'h008_1235, 8'h33, 2'd1, 25'h06F_091A, 2'b10};
		stim[3] = '{8'd1, 25'h00A_0135, 8'h44, 2'd1, 25'h074_009A, 2'b01};
		stim[4] = '{8'd0, 25'h00C_0101, 8'h55, 2'd1, 25'h076_0080, 2'b10};
		// P
		stim[5] = '{8'd2, 25'h000_1000, 8'h60, 2'd1, 25'h000_0000, 2'b01};
		stim[6] = '{8'd2, 25'h000_1001, 8'h61, 2'd1, 25'h000_0000, 2'b10};
		stim[7] = '{8'd2, 25'h000_1002, 8'h62, 2'd1, 25'h000_0001, 2'b01};
		stim[8] = '{8'd2, 25'h000_1003, 8'h63, 2'd1, 25'h000_0001, 2'b10};
		// FIX, shuffled
		stim[9] = '{8'd2, 25'h000_1004, 8'h64, 2'd1, 25'h070_0001, 2'b01};
		stim[10] = '{8'd2, 25'h000_1005, 8'h65, 2'd1, 25'h070_0003, 2'b01};
		// M
		stim[11] = '{8'd2, 25'h000_1006, 8'h66, 2'd1, 25'h078_0000, 2'b01};
		stim[12] = '{8'd2, 25'h000_1007, 8'h67, 2'd1, 25'h078_0000, 2'b10};
		// V1 at C, V2 at C + V1 after the split
		stim[13] = '{8'd2, 25'h000_1008, 8'h68, 2'd2, 25'h000_0002, 2'b01};
		stim[14] = '{8'd2, 25'h000_1009, 8'h69, 2'd2, 25'h000_0002, 2'b10};
		stim[15] = '{8'd2, 25'h000_100A, 8'h6A, 2'd2, 25'h000_0003, 2'b01};
		stim[16] = '{8'd2, 25'h000_100B, 8'h6B, 2'd2, 25'h000_0003, 2'b10};
		// C, shuffled
		stim[17] = '{8'd2, 25'h000_100C, 8'h6C, 2'd2, 25'h000_000E, 2'b01};
		stim[18] = '{8'd2, 25'h000_100D, 8'h6D, 2'd2, 25'h000_000F, 2'b01};
		stim[19] = '{8'd2, 25'h000_100E, 8'h6E, 2'd2, 25'h000_000E, 2'b10};
		stim[20] = '{8'd2, 25'h000_100F, 8'h6F, 2'd2, 25'h000_000F, 2'b10};
		// Past the end of the cart
		stim[21] = '{8'd2, 25'h000_1010, 8'h70, 2'd0, 25'h000_0000, 2'b00};
		stim[22] = '{8'd2, 25'h000_1011, 8'h71, 2'd0, 25'h000_0000, 2'b00};
	endtask

	task automatic send_beat(input logic [7:0] index,
		input logic [`NEO_IOCTL_ADDR_W-1:0] addr, input logic [7:0] data);
		@(posedge CLK_48M);
		#10;
		ioctl.wr = 1'b1;
		ioctl.index = index;
		ioctl.addr = addr;
		ioctl.data = data;
		@(posedge CLK_48M);
		#10;
		ioctl.wr = 1'b0;
	endtask

	// Magic, then six little-endian sizes P S M V1 V2 C, then the last byte
	task automatic send_header();
		logic [31:0] region_bytes [6];
		logic [7:0] magic [4];
		logic [7:0] b;
		region_bytes = '{32'd4, 32'd2, 32'd2, 32'd4, 32'd0, 32'd4};
		magic = '{8'h4E, 8'h45, 8'h4F, 8'h01};
		for (int a = 0; a <= `NEO_SIZE_LAST; a++) begin
			if (a < `NEO_SIZE_FIRST)
				b = magic[a];
			else
				b = 8'(region_bytes[(a - `NEO_SIZE_FIRST) / 4] >>
					(8 * ((a - `NEO_SIZE_FIRST) % 4)));
			send_beat(8'd2, 25'(a), b);
		end
		send_beat(8'd2, 25'(`NEO_HEADER_LAST), 8'h00);
	endtask

	task automatic wait_for_request(input logic [1:0] port, input logic prev,
		output logic seen);
		seen = 1'b0;
		for (int i = 0; i < 4 && !seen; i++) begin
			@(negedge CLK_48M);
			seen = ((port == 2'd1) ? p1_req : p2_req) != prev;
		end
	endtask

	task automatic wait_for_ack(input logic [1:0] port, output logic acked);
		acked = 1'b0;
		for (int i = 0; i < 12 && !acked; i++) begin
			@(negedge CLK_48M);
			acked = (port == 2'd1) ? (p1_ack == p1_req) : (p2_ack == p2_req);
		end
	endtask

	task automatic apply_entry(input int k);
		beat_entry_t e;
		logic p1_prev;
		logic p2_prev;
		logic seen;
		logic acked;
		logic other_quiet;
		logic [31:0] got_addr;
		sdram_wdata_t got_data;
		string pfx;
		int errors_before;
		e = stim[k];
		errors_before = errors;
		p1_prev = p1_req;
		p2_prev = p2_req;
		pick_delay(p1_delay);
		pick_delay(p2_delay);
		send_beat(e.index, e.addr, e.data);
		if (e.port == 2'd0) begin
			repeat (6) @(negedge CLK_48M);
			check_true(p1_req == p1_prev && p2_req == p2_prev,
				$sformatf("entry %0d: a request came after the last cart byte", k));
		end else begin
			wait_for_request(e.port, (e.port == 2'd1) ? p1_prev : p2_prev, seen);
			check_true(seen, $sformatf("entry %0d: no request on port %0d", k, e.port));
			if (seen) begin
				if (e.port == 2'd1) begin
					pfx = "p1";
					got_addr = 32'(p1_addr);
					got_data = p1_wdata;
					other_quiet = (p2_req == p2_prev);
				end else begin
					pfx = "p2";
					got_addr = 32'(p2_addr);
					got_data = p2_wdata;
					other_quiet = (p1_req == p1_prev);
				end
				check_value({pfx, "_addr"}, got_addr, 32'(e.waddr));
				check_value({pfx, "_wdata.data"}, 32'(got_data.data), 32'({e.data, e.data}));
				check_value({pfx, "_wdata.ds"}, 32'(got_data.ds), 32'(e.ds));
				check_true(other_quiet,
					$sformatf("entry %0d: the other port raised a request too", k));
				wait_for_ack(e.port, acked);
				check_true(acked, $sformatf("entry %0d: request never acknowledged", k));
			end
			// Walker passes check_end before the next beat
			repeat (3) @(posedge CLK_48M);
		end
		$display("entry %2d: index %0d addr 0x%h port %0d %s", k, e.index, e.addr,
			e.port, (errors == errors_before) ? "passed" : "failed");
	endtask

	initial begin
		int k;
		int exp_p1;
		int exp_p2;
		int last_p1;
		int last_p2;
		int errors_before;
		rst_n = 1'b0;
		download = 1'b0;
		ioctl = '0;
		p1_delay = 4'd1;
		p2_delay = 4'd1;
		lfsr = 32'h1535_3bff;
		checks = 0;
		errors = 0;
		load_stimulus();
		repeat (RESET_CYCLES) @(posedge CLK_48M);
		#10;
		rst_n = 1'b1;
		download = 1'b1;

		errors_before = errors;
		check_value("p1_req", 32'(p1_req), 32'd0);
		check_value("p2_req", 32'(p2_req), 32'd0);
		repeat (4) @(negedge CLK_48M);
		check_true(!p1_req && !p2_req, "a request toggled before the first beat");
		$display("reset: %s", (errors == errors_before) ? "passed" : "failed");

		errors_before = errors;
		send_header();
		repeat (6) @(negedge CLK_48M);
		check_true(!p1_req && !p2_req && p1_writes == 0 && p2_writes == 0,
			"header bytes caused a write request");
		$display("header: %s", (errors == errors_before) ? "passed" : "failed");

		for (k = 0; k < NUM_ENTRIES; k++) begin
			apply_entry(k);
		end

		// Totals and last writes seen by the models
		errors_before = errors;
		exp_p1 = 0;
		exp_p2 = 0;
		last_p1 = 0;
		last_p2 = 0;
		for (k = 0; k < NUM_ENTRIES; k++) begin
			if (stim[k].port == 2'd1) begin
				exp_p1++;
				last_p1 = k;
			end else if (stim[k].port == 2'd2) begin
				exp_p2++;
				last_p2 = k;
			end
		end
		check_value("p1_writes", 32'(p1_writes), 32'(exp_p1));
		check_value("p2_writes", 32'(p2_writes), 32'(exp_p2));
		check_value("p1_last_addr", 32'(p1_last_addr), 32'(stim[last_p1].waddr));
		check_value("p1_last_wdata", 32'(p1_last_wdata),
			32'({stim[last_p1].data, stim[last_p1].data, stim[last_p1].ds}));
		check_value("p2_last_addr", 32'(p2_last_addr), 32'(stim[last_p2].waddr));
		check_value("p2_last_wdata", 32'(p2_last_wdata),
			32'({stim[last_p2].data, stim[last_p2].data, stim[last_p2].ds}));
		$display("write totals: %s", (errors == errors_before) ? "passed" : "failed");

		$display("%0d checks, %0d passed, %0d failed", checks, checks - errors, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/sdram_port_model.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "neo_loader_config.svh"

module sdram_port_model
	import neo_loader_pkg::*;
#(
	parameter int ADDR_W = `NEO_PORT1_ADDR_W - 1
) (
	input logic CLK_48M,
	input logic rst_n,
	input logic [3:0] delay,
	input logic req,
	input logic [ADDR_W-1:0] addr,
	input sdram_wdata_t wdata,
	output logic ack,
	output logic [ADDR_W-1:0] last_addr,
	output sdram_wdata_t last_wdata,
	output int writes
);

	int wait_left;

	// Ack follows req after delay cycles, counted from the toggle
	initial begin
		ack = 1'b0;
		writes = 0;
		last_addr = '0;
		last_wdata = '0;
		forever begin
			@(posedge CLK_48M);
			#10;
			if (!rst_n) begin
				ack = 1'b0;
			end else if (req != ack) begin
				wait_left = int'(delay);
				while (wait_left > 1) begin
					@(posedge CLK_48M);
					#10;
					wait_left--;
				end
				// Written word as the controller would see it
				last_addr = addr;
				last_wdata = wdata;
				writes++;
				ack = req;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/neo_cart_loader.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "neo_loader_config.svh"

module neo_cart_loader
	import neo_loader_pkg::*;
(
	input logic CLK_48M,
	input logic rst_n,
	input ioctl_beat_t ioctl,
	input logic download,
	output logic p1_req,
	output logic [`NEO_PORT1_ADDR_W-2:0] p1_addr,
	output sdram_wdata_t p1_wdata,
	input logic p1_ack,
	output logic p2_req,
	output logic [`NEO_PORT2_ADDR_W-2:0] p2_addr,
	output sdram_wdata_t p2_wdata,
	input logic p2_ack
);

	rom_sizes_t sizes;
	logic header_end;
	logic p1_wr;
	logic p2_wr;
	logic p1_idle;
	logic p2_idle;
	logic [`NEO_PORT1_ADDR_W-2:0] p1_waddr;
	logic [`NEO_PORT2_ADDR_W-2:0] p2_waddr;
	sdram_wdata_t wdata;

	neo_header_parser header_parser (
		.CLK_48M(CLK_48M),
		.rst_n(rst_n),
		.ioctl(ioctl),
		.download(download),
		.sizes(sizes),
		.header_end(header_end)
	);

	neo_region_walker region_walker (
		.CLK_48M(CLK_48M),
		.rst_n(rst_n),
		.ioctl(ioctl),
		.download(download),
		.sizes(sizes),
		.header_end(header_end),
		.p1_wr(p1_wr),
		.p2_wr(p2_wr),
		.p1_addr(p1_waddr),
		.p2_addr(p2_waddr),
		.wdata(wdata),
		.p1_idle(p1_idle),
		.p2_idle(p2_idle)
	);

	// Bank 3
	sdram_write_port #(.ADDR_W(`NEO_PORT1_ADDR_W - 1)) p1_port (
		.CLK_48M(CLK_48M),
		.rst_n(rst_n),
		.wr(p1_wr),
		.addr_in(p1_waddr),
		.wdata_in(wdata),
		.idle(p1_idle),
		.req(p1_req),
		.ack(p1_ack),
		.addr(p1_addr),
		.wdata(p1_wdata)
	);

	// Banks 0-2
	sdram_write_port #(.ADDR_W(`NEO_PORT2_ADDR_W - 1)) p2_port (
		.CLK_48M(CLK_48M),
		.rst_n(rst_n),
		.wr(p2_wr),
		.addr_in(p2_waddr),
		.wdata_in(wdata),
		.idle(p2_idle),
		.req(p2_req),
		.ack(p2_ack),
		.addr(p2_addr),
		.wdata(p2_wdata)
	);

endmodule

`default_nettype wire

// ==== hdl/neo_header_parser.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "neo_loader_config.svh"

module neo_header_parser
	import neo_loader_pkg::*;
(
	input logic CLK_48M,
	input logic rst_n,
	input ioctl_beat_t ioctl,
	input logic download,
	output rom_sizes_t sizes,
	output logic header_end
);

	localparam int SIZES_W = $bits(rom_sizes_t);

	logic header_beat;
	logic size_byte;
	logic last_byte;

	// Cart download, first 4 KiB of the file
	assign header_beat = ioctl.wr && download && (ioctl.index == 8'd2) &&
		(ioctl.addr <= `NEO_HEADER_LAST);

	assign size_byte = (ioctl.addr >= `NEO_SIZE_FIRST) && (ioctl.addr <= `NEO_SIZE_LAST);
	assign last_byte = (ioctl.addr == `NEO_HEADER_LAST);

	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			sizes <= '0;
			header_end <= 1'b0;
		end else begin
			header_end <= 1'b0;
			if (header_beat) begin
				// Six little-endian words, one byte per beat
				if (size_byte) begin
					sizes <= {ioctl.data, sizes[SIZES_W-1:8]};
				end
				if (last_byte) begin
					header_end <= 1'b1;
					// Both ADPCM ROMs merged into V1 by the file builder
					if (sizes.v2 == 32'd0) begin
						sizes.v1 <= sizes.v1 >> 1;
						sizes.v2 <= sizes.v1 >> 1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/neo_loader_config.svh ====
`ifndef NEO_LOADER_CONFIG_SVH
`define NEO_LOADER_CONFIG_SVH

// Download channel
`define NEO_IOCTL_ADDR_W 25

// Byte address widths of the two SDRAM write ports
`define NEO_PORT1_ADDR_W 24
`define NEO_PORT2_ADDR_W 26

// .NEO header layout
`define NEO_HEADER_LAST 4095
`define NEO_SIZE_FIRST 4
`define NEO_SIZE_LAST 27
`define NEO_REGION_COUNT 6

// Bank 3 region bases, byte addresses
`define NEO_FIX_BASE 24'hE0_0000
`define NEO_MROM_BASE 24'hF0_0000
`define NEO_SROM_BASE 24'hF8_0000
`define NEO_LOROM_BASE 24'hDE_0000
`define NEO_SFIX_BASE 24'hE8_0000
`define NEO_SM1_BASE 24'hEC_0000

`endif

// ==== hdl/neo_loader_pkg.sv ====
`default_nettype none

`include "neo_loader_config.svh"

package neo_loader_pkg;

	// One byte from the host download channel
	typedef struct packed {
		logic wr;
		logic [7:0] index;
		logic [`NEO_IOCTL_ADDR_W-1:0] addr;
		logic [7:0] data;
	} ioctl_beat_t;

	// Region sizes in bytes, P in the low word so the header shifts in LSB first
	typedef struct packed {
		logic [31:0] c;
		logic [31:0] v2;
		logic [31:0] v1;
		logic [31:0] m;
		logic [31:0] s;
		logic [31:0] p;
	} rom_sizes_t;

	// Byte duplicated on both lanes, strobe selects the lane
	typedef struct packed {
		logic [15:0] data;
		logic [1:0] ds;
	} sdram_wdata_t;

	typedef enum logic [2:0] {
		prom,
		srom,
		mrom,
		v1rom,
		v2rom,
		crom,
		done
	} region_e;

	typedef enum logic [1:0] {
		idle,
		wait_ack,
		check_end
	} walk_state_e;

endpackage

`default_nettype wire

// ==== hdl/neo_region_walker.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "neo_loader_config.svh"

module neo_region_walker
	import neo_loader_pkg::*;
(
	input logic CLK_48M,
	input logic rst_n,
	input ioctl_beat_t ioctl,
	input logic download,
	input rom_sizes_t sizes,
	input logic header_end,
	output logic p1_wr,
	output logic p2_wr,
	output logic [`NEO_PORT1_ADDR_W-2:0] p1_addr,
	output logic [`NEO_PORT2_ADDR_W-2:0] p2_addr,
	output sdram_wdata_t wdata,
	input logic p1_idle,
	input logic p2_idle
);

	localparam int P1_W = `NEO_PORT1_ADDR_W;
	localparam int P2_W = `NEO_PORT2_ADDR_W;

	region_e region;
	walk_state_e state;
	logic [P2_W-1:0] offset;
	logic [P2_W-1:0] region_size;

	logic sys_beat;
	logic cart_beat;
	logic cart_to_p1;
	logic to_p1;
	logic wr_pend;
	logic cart_idle;
	logic lane;
	logic [P1_W-1:0] sys_addr;
	logic [P1_W-1:0] cart_p1_addr;
	logic [P1_W-1:0] p1_byte;
	logic [P2_W-1:0] cart_p2_addr;

	// FIX tile byte order
	function automatic logic [18:0] fix_shuffle(input logic [18:0] a);
		return {a[18:5], a[2:0], ~a[4], a[3]};
	endfunction

	assign sys_beat = ioctl.wr && download && (ioctl.index == 8'd0 || ioctl.index == 8'd1);
	assign cart_beat = ioctl.wr && download && (ioctl.index == 8'd2) &&
		(ioctl.addr > `NEO_HEADER_LAST) && (region != done);

	assign cart_to_p1 = (region <= mrom);
	assign to_p1 = sys_beat || cart_to_p1;
	assign wr_pend = p1_wr || p2_wr;
	assign cart_idle = cart_to_p1 ? p1_idle : p2_idle;

	// System ROM map on bank 3
	always_comb begin
		if (ioctl.addr < 25'h008_0000)
			sys_addr = `NEO_SROM_BASE + {5'd0, ioctl.addr[18:0]};
		else if (ioctl.addr < 25'h00A_0000)
			sys_addr = `NEO_LOROM_BASE + {8'd0, ioctl.addr[15:0]};
		else if (ioctl.addr < 25'h00C_0000)
			sys_addr = `NEO_SFIX_BASE + {5'd0, fix_shuffle({2'b00, ioctl.addr[16:0]})};
		else
			sys_addr = `NEO_SM1_BASE + {6'd0, ioctl.addr[17:0]};
	end

	always_comb begin
		case (region)
			srom: cart_p1_addr = `NEO_FIX_BASE + {5'd0, fix_shuffle(offset[18:0])};
			mrom: cart_p1_addr = `NEO_MROM_BASE + {5'd0, offset[18:0]};
			default: cart_p1_addr = offset[P1_W-1:0];
		endcase
	end

	// V1 and V2 sit above the sprite data in banks 0-2
	always_comb begin
		case (region)
			v1rom: cart_p2_addr = sizes.c[P2_W-1:0] + offset;
			v2rom: cart_p2_addr = sizes.c[P2_W-1:0] + sizes.v1[P2_W-1:0] + offset;
			default: cart_p2_addr = {offset[25:7], ioctl.addr[5:2], ~ioctl.addr[6],
				ioctl.addr[0], ioctl.addr[1]};
		endcase
	end

	always_comb begin
		case (region)
			prom: region_size = sizes.p[P2_W-1:0];
			srom: region_size = sizes.s[P2_W-1:0];
			mrom: region_size = sizes.m[P2_W-1:0];
			v1rom: region_size = sizes.v1[P2_W-1:0];
			v2rom: region_size = sizes.v2[P2_W-1:0];
			crom: region_size = sizes.c[P2_W-1:0];
			default: region_size = '0;
		endcase
	end

	assign p1_byte = sys_beat ? sys_addr : cart_p1_addr;
	assign lane = to_p1 ? p1_byte[0] : cart_p2_addr[0];

	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			p1_wr <= 1'b0;
			p2_wr <= 1'b0;
		end else begin
			p1_wr <= (sys_beat || cart_beat) && to_p1;
			p2_wr <= cart_beat && !to_p1;
		end
	end

	always_ff @(posedge CLK_48M) begin
		p1_addr <= p1_byte[P1_W-1:1];
		p2_addr <= cart_p2_addr[P2_W-1:1];
		wdata.data <= {ioctl.data, ioctl.data};
		wdata.ds <= {lane, ~lane};
	end

	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			region <= prom;
			offset <= '0;
		end else if (header_end) begin
			// Skip empty regions before the first data byte
			region <= prom;
			offset <= '0;
			state <= check_end;
		end else begin
			case (state)
				idle:
					if (cart_beat)
						state <= wait_ack;
				wait_ack:
					if (!wr_pend && cart_idle) begin
						offset <= offset + 1'b1;
						state <= check_end;
					end
				check_end:
					if (offset == region_size) begin
						offset <= '0;
						region <= region_e'(region + 1'b1);
						if (region == region_e'(`NEO_REGION_COUNT - 1))
							state <= idle;
					end else begin
						state <= idle;
					end
				default:
					state <= idle;
			endcase
		end
	end

	// Host link must not outrun the SDRAM
	a_beat_when_ready: assert property (
		@(posedge CLK_48M) disable iff (!rst_n)
		(sys_beat || cart_beat) |-> !wr_pend && (state == idle) &&
			(to_p1 ? p1_idle : p2_idle)
	);

endmodule

`default_nettype wire

// ==== hdl/sdram_write_port.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "neo_loader_config.svh"

module sdram_write_port
	import neo_loader_pkg::*;
#(
	parameter int ADDR_W = `NEO_PORT1_ADDR_W - 1
) (
	input logic CLK_48M,
	input logic rst_n,
	input logic wr,
	input logic [ADDR_W-1:0] addr_in,
	input sdram_wdata_t wdata_in,
	output logic idle,
	output logic req,
	input logic ack,
	output logic [ADDR_W-1:0] addr,
	output sdram_wdata_t wdata
);

	// Toggle handshake, done once ack catches up
	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n)
			req <= 1'b0;
		else if (wr)
			req <= ~req;
	end

	always_ff @(posedge CLK_48M) begin
		if (wr) begin
			addr <= addr_in;
			wdata <= wdata_in;
		end
	end

	assign idle = (req == ack);

	a_no_wr_busy: assert property (
		@(posedge CLK_48M) disable iff (!rst_n)
		wr |-> idle
	);

	// Controller may sample at any point until ack
	a_hold_busy: assert property (
		@(posedge CLK_48M) disable iff (!rst_n)
		!idle |=> $stable(addr) && $stable(wdata)
	);

endmodule

`default_nettype wire

// ==== neo_cart_loader.f ====
+incdir+hdl
hdl/neo_loader_pkg.sv
hdl/neo_header_parser.sv
hdl/neo_region_walker.sv
hdl/sdram_write_port.sv
hdl/neo_cart_loader.sv
dv/sdram_port_model.sv
dv/neo_cart_loader_tb.sv
